/* filelist.f */
hw/acq_pkg.sv
hw/spi_adc_reader.sv
hw/frame_packer.sv
hw/frame_ram.sv
hw/frame_sender.sv
hw/acq_console.sv
hw/acq_top.sv
tb/acq_checker.sv
tb/acq_tb.sv

/* Bender.yml */
package:
  name: acq_path

sources:
  - hw/acq_pkg.sv
  - hw/spi_adc_reader.sv
  - hw/frame_packer.sv
  - hw/frame_ram.sv
  - hw/frame_sender.sv
  - hw/acq_console.sv
  - hw/acq_top.sv
  - target: test
    files:
      - tb/acq_checker.sv
      - tb/acq_tb.sv

/* tb/acq_tb.sv */
`timescale 1ns/1ns

module acq_tb;
    localparam int TOTAL_FRAMES = 10;
    localparam int HOLD_CYCLES = 600;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * (272 + 12 + 11 * HOLD_CYCLES) + 2000;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    logic              busy;
    logic              spi_miso = 1'b0;
    logic              spi_sclk;
    logic              spi_cs_n;
    logic              spi_mosi;
    logic              tx_valid;
    logic              tx_credit = 1'b0;
    acq_pkg::btype_t   btype;
    acq_pkg::seq_t     frame_count;
    acq_pkg::tx_byte_t tx;
    logic [127:0]      test_name;
    logic [31:0]       lfsr = 32'd84125;
    logic [15:0]       miso_word;
    logic              prev_cs = 1'b1;
    logic              prev_sclk = 1'b0;
    logic              hold_credits = 1'b0;
    int                cyc = 0;
    int                credit_due [$];
    int                error_count;
    int                frame_total;
    int                tb_errors = 0;

    always #4 clk = ~clk;

    acq_top i_dut (.*);

    acq_checker i_checker (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // ADC model and credit return share the LFSR
    always @(negedge clk) begin
        cyc++;
        if (prev_cs && !spi_cs_n) begin
            miso_word = take_bits(12);
            spi_miso = miso_word[15];
        end else if (prev_sclk && !spi_sclk && !spi_cs_n) begin
            miso_word = miso_word << 1;
            spi_miso = miso_word[15];
        end
        prev_cs = spi_cs_n;
        prev_sclk = spi_sclk;
        if (tx_valid) begin
            credit_due.push_back(cyc + 1 + int'(take_bits(4)));
        end
        tx_credit = 1'b0;
        if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cyc) begin
            tx_credit = 1'b1;
            void'(credit_due.pop_front());
        end
    end

    task automatic run_request(input logic [127:0] name, input logic [3:0] bt,
                               input logic [3:0] cnt);
        @(negedge clk);
        test_name = name;
        btype = bt;
        frame_count = cnt;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_idle;
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        btype = '0;
        frame_count = '0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (50) @(negedge clk);
        run_request("single_frame", 4'h0, 4'd1);
        wait_idle();
        run_request("five_frames", 4'h9, 4'd5);
        repeat (100) @(negedge clk);
        // Second request while busy, must be dropped
        btype = 4'h2;
        frame_count = 4'd3;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_idle();
        run_request("back_pressure", 4'h6, 4'd3);
        while (!tx_valid) begin
            @(negedge clk);
        end
        hold_credits = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        hold_credits = 1'b0;
        wait_idle();
        run_request("zero_count", 4'hc, 4'd0);
        wait_idle();
        if (frame_total != TOTAL_FRAMES) begin
            $display("Wrong frame total: %0d sent, %0d requested", frame_total, TOTAL_FRAMES);
            tb_errors++;
        end
        $display("Closing report: %0d errors, %0d frames checked",
                 error_count + tb_errors, frame_total);
        if (error_count + tb_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with the tests unfinished", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* tb/acq_checker.sv */
`timescale 1ns/1ns

module acq_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [127:0]      test_name,
    input  logic              start,
    input  acq_pkg::btype_t   btype,
    input  acq_pkg::seq_t     frame_count,
    input  logic              busy,
    input  logic              spi_miso,
    input  logic              spi_sclk,
    input  logic              spi_cs_n,
    input  logic              spi_mosi,
    input  acq_pkg::tx_byte_t tx,
    input  logic              tx_valid,
    input  logic              tx_credit,
    output int                error_count,
    output int                frame_total
);
    logic [47:0] conv_q [$];
    logic [47:0] cur_set;
    logic [15:0] miso_sh;
    logic [15:0] mosi_sh;
    logic [7:0]  xor_acc;
    logic [3:0]  btype_exp;
    logic [3:0]  seq_exp;
    logic        started;
    logic        accept_q;
    logic        prev_cs;
    logic        prev_sclk;
    logic        prev_busy;
    int          bit_n;
    int          ch_exp;
    int          byte_idx;
    int          outstanding;
    int          req_frames;
    int          frames_in_req;

    initial begin
        error_count = 0;
        frame_total = 0;
    end

    // Frame bytes 0 to 9
    function automatic logic [7:0] body_byte(input logic [3:0] bt, input logic [3:0] sq,
                                             input logic [47:0] set, input int idx);
        logic [11:0] s;
        int k;
        if (idx == 0) begin
            return 8'hA5;
        end else if (idx == 1) begin
            return {bt, sq};
        end
        k = (idx - 2) / 2;
        s = set[k*12 +: 12];
        if (idx % 2 == 0) begin
            return {4'(k), s[11:8]};
        end
        return s[7:0];
    endfunction

    function automatic logic [7:0] ref_frame_byte(input logic [3:0] bt, input logic [3:0] sq,
                                                  input logic [47:0] set, input int idx);
        logic [7:0] x;
        int i;
        x = 8'h00;
        if (idx < 10) begin
            return body_byte(bt, sq, set, idx);
        end
        for (i = 0; i < 10; i++) begin
            x = x ^ body_byte(bt, sq, set, i);
        end
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            error_count++;
            $display("FAIL %0s %0s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic flag_error(input string what);
        error_count++;
        $display("Error in %0s: %0s", test_name, what);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            conv_q.delete();
            started = 1'b0;
            accept_q = 1'b0;
            prev_cs = 1'b1;
            prev_sclk = 1'b0;
            prev_busy = 1'b0;
            ch_exp = 0;
            byte_idx = 0;
            outstanding = 0;
        end else begin
            if (!started && (busy || tx_valid || !spi_cs_n || spi_sclk)) begin
                flag_error("outputs left their reset state before the first start");
            end
            if (accept_q && !busy) begin
                flag_error("busy did not rise the cycle after start");
            end
            accept_q = start && !busy;
            if (start && !busy) begin
                started = 1'b1;
                btype_exp = btype;
                seq_exp = 4'd0;
                frames_in_req = 0;
                req_frames = (frame_count == 4'd0) ? 1 : int'(frame_count);
            end
            // SPI side, rebuilt from the pins
            if (prev_cs && !spi_cs_n) begin
                bit_n = 0;
            end
            if (!spi_cs_n && !prev_sclk && spi_sclk) begin
                miso_sh = {miso_sh[14:0], spi_miso};
                mosi_sh = {mosi_sh[14:0], spi_mosi};
                bit_n++;
            end
            if (!prev_cs && spi_cs_n) begin
                check_value("SCLK periods per channel", 16, bit_n);
                check_value("MOSI command bits", {2'b01, 2'(ch_exp)}, mosi_sh[15:12]);
                cur_set[ch_exp*12 +: 12] = miso_sh[11:0];
                ch_exp++;
                if (ch_exp == 4) begin
                    conv_q.push_back(cur_set);
                    ch_exp = 0;
                end
            end
            prev_cs = spi_cs_n;
            prev_sclk = spi_sclk;
            outstanding = outstanding + int'(tx_valid) - int'(tx_credit);
            if (outstanding > 4 || outstanding < 0) begin
                flag_error($sformatf("%0d bytes outstanding against the credits", outstanding));
            end
            if (tx_valid && conv_q.size() == 0) begin
                flag_error("a byte was sent with no finished conversion behind it");
            end else if (tx_valid) begin
                if (byte_idx == 0) begin
                    xor_acc = 8'h00;
                end
                check_value($sformatf("byte %0d", byte_idx),
                            ref_frame_byte(btype_exp, seq_exp, conv_q[0], byte_idx), tx.data);
                check_value($sformatf("last flag on byte %0d", byte_idx),
                            byte_idx == 10, tx.last);
                if (byte_idx == 10) begin
                    check_value("checksum against received bytes", xor_acc, tx.data);
                end
                if (!busy) begin
                    flag_error("busy was low while a byte was sent");
                end
                xor_acc = xor_acc ^ tx.data;
                if (byte_idx == 10) begin
                    void'(conv_q.pop_front());
                    byte_idx = 0;
                    seq_exp++;
                    frames_in_req++;
                    frame_total++;
                end else begin
                    byte_idx++;
                end
            end
            if (prev_busy && !busy) begin
                check_value("frames per request", req_frames, frames_in_req);
                check_value("conversions left over", 0, conv_q.size());
            end
            prev_busy = busy;
        end
    end

endmodule

/* hw/acq_top.sv */
`timescale 1ns/1ns

module acq_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  acq_pkg::btype_t   btype,
    input  acq_pkg::seq_t     frame_count,
    output logic              busy,
    input  logic              spi_miso,
    output logic              spi_sclk,
    output logic              spi_cs_n,
    output logic              spi_mosi,
    output acq_pkg::tx_byte_t tx,
    output logic              tx_valid,
    input  logic              tx_credit
);
    // Control section
    logic fs_conv, fd_conv;
    logic fs_pack, fd_pack;
    logic fs_send, fd_send;
    acq_pkg::btype_t frame_btype;
    acq_pkg::seq_t   frame_seq;

    // ADC and RAM section
    acq_pkg::sample_set_t samples;
    acq_pkg::ram_wr_t     ram_wr;
    acq_pkg::ram_addr_t   rd_addr;
    acq_pkg::byte_t       rd_data;

    acq_console
    i_console(
        .clk, .rst_n,
        .start, .btype, .frame_count,
        .fd_conv, .fd_pack, .fd_send,
        .busy,
        .fs_conv, .fs_pack, .fs_send,
        .frame_btype, .frame_seq
    );

    spi_adc_reader
    i_reader(
        .clk, .rst_n,
        .fs_conv, .fd_conv,
        .samples,
        .spi_miso, .spi_sclk, .spi_cs_n, .spi_mosi
    );

    frame_packer
    i_packer(
        .clk, .rst_n,
        .fs_pack, .fd_pack,
        .frame_btype, .frame_seq,
        .samples,
        .ram_wr
    );

    frame_ram
    i_ram(
        .clk,
        .ram_wr,
        .rd_addr, .rd_data
    );

    frame_sender
    i_sender(
        .clk, .rst_n,
        .fs_send, .fd_send,
        .frame_seq,
        .rd_data, .rd_addr,
        .tx_credit, .tx, .tx_valid
    );

endmodule

/* hw/acq_console.sv */
`timescale 1ns/1ns

module acq_console (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  acq_pkg::btype_t btype,
    input  acq_pkg::seq_t   frame_count,
    input  logic            fd_conv,
    input  logic            fd_pack,
    input  logic            fd_send,
    output logic            busy,
    output logic            fs_conv,
    output logic            fs_pack,
    output logic            fs_send,
    output acq_pkg::btype_t frame_btype,
    output acq_pkg::seq_t   frame_seq
);
    acq_pkg::console_state_t state;
    acq_pkg::seq_t           remaining;
    acq_pkg::seq_t           next_seq;
    logic                    send_pending;
    logic                    accept;
    logic                    pack_go;

    assign busy    = (state != acq_pkg::IDLE);
    assign accept  = (state == acq_pkg::IDLE) && start;
    // Bank of the previous frame must be fully sent before repacking
    assign pack_go = (state == acq_pkg::WAIT_SEND) && (remaining != '0) && !send_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= acq_pkg::IDLE;
            remaining    <= '0;
            send_pending <= 1'b0;
            fs_conv      <= 1'b0;
            fs_pack      <= 1'b0;
            fs_send      <= 1'b0;
        end else begin
            fs_conv <= 1'b0;
            fs_pack <= 1'b0;
            fs_send <= 1'b0;
            if (fd_send) begin
                send_pending <= 1'b0;
            end
            case (state)
                acq_pkg::IDLE: begin
                    if (accept) begin
                        // Zero frames runs as one
                        remaining <= (frame_count == '0) ? 4'd1 : frame_count;
                        fs_conv   <= 1'b1;
                        state     <= acq_pkg::CONV;
                    end
                end
                acq_pkg::CONV: begin
                    if (fd_conv) begin
                        state <= acq_pkg::WAIT_SEND;
                    end
                end
                acq_pkg::WAIT_SEND: begin
                    if (pack_go) begin
                        fs_pack <= 1'b1;
                        state   <= acq_pkg::PACK;
                    end else if (remaining == '0 && fd_send) begin
                        state <= acq_pkg::IDLE;
                    end
                end
                acq_pkg::PACK: begin
                    if (fd_pack) begin
                        fs_send      <= 1'b1;
                        send_pending <= 1'b1;
                        remaining    <= remaining - 4'd1;
                        // Next conversion overlaps this send
                        if (remaining != 4'd1) begin
                            fs_conv <= 1'b1;
                            state   <= acq_pkg::CONV;
                        end else begin
                            state <= acq_pkg::WAIT_SEND;
                        end
                    end
                end
                default: state <= acq_pkg::IDLE;
            endcase
        end
    end

    // frame_seq holds through packing and the send start
    always_ff @(posedge clk) begin
        if (accept) begin
            frame_btype <= btype;
            next_seq    <= '0;
        end
        if (pack_go) begin
            frame_seq <= next_seq;
            next_seq  <= next_seq + 4'd1;
        end
    end

endmodule

/* hw/frame_sender.sv */
`timescale 1ns/1ns

module frame_sender (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fs_send,
    input  acq_pkg::seq_t       frame_seq,
    input  acq_pkg::byte_t      rd_data,
    input  logic                tx_credit,
    output logic                fd_send,
    output acq_pkg::ram_addr_t  rd_addr,
    output acq_pkg::tx_byte_t   tx,
    output logic                tx_valid
);
    logic             active;
    logic             bank;
    logic [3:0]       rd_idx;
    logic             issue;
    logic             last_q;
    acq_pkg::credit_t credits;

    // A read only goes out when a credit covers its byte
    assign issue   = active && (credits != '0);
    assign rd_addr = {bank, rd_idx};

    // RAM data arrives with the valid one cycle after the read
    assign tx.data = rd_data;
    assign tx.last = last_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            bank     <= 1'b0;
            rd_idx   <= '0;
            last_q   <= 1'b0;
            tx_valid <= 1'b0;
            fd_send  <= 1'b0;
            credits  <= acq_pkg::credit_t'(acq_pkg::CREDIT_MAX);
        end else begin
            tx_valid <= issue;
            fd_send  <= tx_valid && last_q;
            if (issue) begin
                last_q <= (rd_idx == acq_pkg::FRAME_BYTES - 1);
            end
            if (fs_send && !active) begin
                active <= 1'b1;
                bank   <= frame_seq[0];
                rd_idx <= '0;
            end else if (issue) begin
                rd_idx <= rd_idx + 4'd1;
                if (rd_idx == acq_pkg::FRAME_BYTES - 1) begin
                    active <= 1'b0;
                end
            end
            // Simultaneous return and send cancel out
            case ({issue, tx_credit})
                2'b10: credits <= credits - 3'd1;
                2'b01: begin
                    if (credits != acq_pkg::CREDIT_MAX) begin
                        credits <= credits + 3'd1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* hw/frame_ram.sv */
`timescale 1ns/1ns

module frame_ram (
    input  logic                clk,
    input  acq_pkg::ram_wr_t    ram_wr,
    input  acq_pkg::ram_addr_t  rd_addr,
    output acq_pkg::byte_t      rd_data
);
    // Two banks of 16 bytes
    acq_pkg::byte_t mem [0:(1 << acq_pkg::RAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/frame_packer.sv */
`timescale 1ns/1ns

module frame_packer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fs_pack,
    input  acq_pkg::btype_t      frame_btype,
    input  acq_pkg::seq_t        frame_seq,
    input  acq_pkg::sample_set_t samples,
    output logic                 fd_pack,
    output acq_pkg::ram_wr_t     ram_wr
);
    logic             active;
    logic [3:0]       idx;
    logic [3:0]       pos;
    logic [1:0]       k;
    acq_pkg::btype_t  btype_q;
    acq_pkg::seq_t    seq_q;
    acq_pkg::byte_t   csum;
    acq_pkg::byte_t   cur_byte;
    acq_pkg::sample_t smp;

    // Sample bytes start at index 2, two per channel
    assign pos = idx - 4'd2;
    assign k   = pos[2:1];
    assign smp = samples.ch[k];

    always_comb begin
        if (idx == 4'd0) begin
            cur_byte = acq_pkg::SYNC_BYTE;
        end else if (idx == 4'd1) begin
            cur_byte = {btype_q, seq_q};
        end else if (idx == acq_pkg::FRAME_BYTES - 1) begin
            cur_byte = csum;
        end else if (!pos[0]) begin
            cur_byte = {2'b00, k, smp[11:8]};
        end else begin
            cur_byte = smp[7:0];
        end
    end

    // Bank select from seq bit 0
    assign ram_wr.en   = active;
    assign ram_wr.addr = {seq_q[0], idx};
    assign ram_wr.data = cur_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            idx     <= '0;
            fd_pack <= 1'b0;
        end else begin
            fd_pack <= 1'b0;
            if (fs_pack && !active) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active) begin
                idx <= idx + 4'd1;
                if (idx == acq_pkg::FRAME_BYTES - 1) begin
                    active  <= 1'b0;
                    fd_pack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_pack && !active) begin
            btype_q <= frame_btype;
            seq_q   <= frame_seq;
            csum    <= '0;
        end else if (active) begin
            csum <= csum ^ cur_byte;
        end
    end

endmodule

/* hw/spi_adc_reader.sv */
`timescale 1ns/1ns

module spi_adc_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fs_conv,
    output logic                 fd_conv,
    output acq_pkg::sample_set_t samples,
    input  logic                 spi_miso,
    output logic                 spi_sclk,
    output logic                 spi_cs_n,
    output logic                 spi_mosi
);
    logic                      active;
    logic [6:0]                cnt;
    logic [1:0]                ch;
    logic [6:0]                tick;
    logic [3:0]                bit_idx;
    logic [1:0]                sub;
    logic                      in_xfer;
    logic [acq_pkg::SPI_BITS-1:0] cmd;
    acq_pkg::sample_t          shreg;

    // Position inside the SCLK part of a channel transfer
    assign tick    = cnt - 7'(acq_pkg::CS_SETUP);
    assign bit_idx = 4'(tick / acq_pkg::SCLK_PERIOD);
    assign sub     = 2'(tick % acq_pkg::SCLK_PERIOD);
    assign in_xfer = active && (cnt >= acq_pkg::CS_SETUP) && (cnt < acq_pkg::XFER_END);

    // Command word: 0, 1, channel number, then zeros
    assign cmd = {2'b01, ch, {(acq_pkg::SPI_BITS - 4){1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            cnt     <= '0;
            ch      <= '0;
            fd_conv <= 1'b0;
        end else begin
            fd_conv <= 1'b0;
            if (fs_conv && !active) begin
                active <= 1'b1;
                cnt    <= '0;
                ch     <= '0;
            end else if (active) begin
                if (cnt == acq_pkg::CH_CYCLES - 1) begin
                    cnt <= '0;
                    ch  <= ch + 2'd1;
                    if (ch == acq_pkg::NUM_CH - 1) begin
                        active <= 1'b0;
                    end
                end else begin
                    cnt <= cnt + 7'd1;
                end
                // One cycle early so done lines up with the final count
                if (ch == acq_pkg::NUM_CH - 1 && cnt == acq_pkg::CH_CYCLES - 2) begin
                    fd_conv <= 1'b1;
                end
            end
        end
    end

    // SPI pins are registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs_n <= 1'b1;
            spi_sclk <= 1'b0;
            spi_mosi <= 1'b0;
        end else begin
            spi_cs_n <= !(active && (cnt < acq_pkg::XFER_END));
            spi_sclk <= in_xfer && (sub >= acq_pkg::SCLK_HALF);
            if (in_xfer && sub == 2'd0) begin
                spi_mosi <= cmd[acq_pkg::SPI_BITS - 1 - bit_idx];
            end else if (!active) begin
                spi_mosi <= 1'b0;
            end
        end
    end

    // MISO taken on the rising SCLK edge; last 12 bits are the sample
    always_ff @(posedge clk) begin
        if (in_xfer && sub == acq_pkg::SCLK_HALF) begin
            shreg <= {shreg[acq_pkg::SAMPLE_W-2:0], spi_miso};
        end
        if (active && cnt == acq_pkg::XFER_END) begin
            samples.ch[ch] <= shreg;
        end
    end

endmodule

/* hw/acq_pkg.sv */
package acq_pkg;

    localparam int NUM_CH = 4;
    localparam int SAMPLE_W = 12;
    localparam int SPI_BITS = 16;
    localparam int SCLK_HALF = 2;
    localparam int FRAME_BYTES = 11;
    localparam logic [7:0] SYNC_BYTE = 8'hA5;
    localparam int CREDIT_MAX = 4;
    localparam int RAM_AW = 5;

    // Per-channel SPI transfer layout, in clk cycles
    localparam int CS_SETUP = 2;
    localparam int CS_HOLD = 2;
    localparam int SCLK_PERIOD = 2 * SCLK_HALF;
    localparam int XFER_END = CS_SETUP + SPI_BITS * SCLK_PERIOD;
    localparam int CH_CYCLES = XFER_END + CS_HOLD;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [7:0] byte_t;
    typedef logic [3:0] btype_t;
    typedef logic [3:0] seq_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;
    typedef logic [2:0] credit_t;

    // ch[0] sits in the low bits
    typedef struct packed {
        sample_t [NUM_CH-1:0] ch;
    } sample_set_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } tx_byte_t;

    typedef enum logic [1:0] {
        IDLE,
        CONV,
        PACK,
        WAIT_SEND
    } console_state_t;

endpackage
